//--- project.f
+incdir+src
src/cam_bridge_pkg.sv
src/cam_bridge_ifs.sv
src/bringup_sequencer.sv
src/rate_meter.sv
src/status_apb_regs.sv
src/cam_bridge_top.sv
verification/cam_bridge_tb.sv

//--- Bender.yml
package:
  name: cam_bridge

sources:
  - include_dirs:
      - src
    files:
      - src/cam_bridge_pkg.sv
      - src/cam_bridge_ifs.sv
      - src/bringup_sequencer.sv
      - src/rate_meter.sv
      - src/status_apb_regs.sv
      - src/cam_bridge_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/cam_bridge_tb.sv

//--- verification/cam_bridge_tb.sv
`include "cam_bridge_config.svh"

module cam_bridge_tb;

    localparam int CLK_PERIOD = 100;
    localparam logic [31:0] LCG_SEED = 32'ha6ef;
    // reset, test 1, bring-up, pins, rate window, apb errors
    localparam int PLAN_CYCLES = 5 + 20 + 200 + 40 + 470 + 60;
    localparam int WATCHDOG_CYCLES = PLAN_CYCLES + 500;
    localparam int RATE_WINDOW = 400;

    logic cam_port = 1'b0;
    logic rst_n = 1'b0;
    logic i_mac_init_done, i_cam_init_done, i_mem_ready;
    logic i_mac_mdc, i_mac_mdio_o, i_mac_mdio_oe;
    logic i_cam_scl_o, i_cam_scl_oe, i_cam_sda_o, i_cam_sda_oe;
    logic i_scl_mdc, i_sda_mdio;
    logic i_vsync, i_jpeg_done;
    logic i_psel, i_penable, i_pwrite;
    logic [`CB_ADDR_W-1:0] i_paddr;
    logic [`CB_WIN_W-1:0] i_pwdata;
    logic [`CB_WIN_W-1:0] o_prdata;
    logic o_pready, o_pslverr;
    logic o_mem_rst_n, o_mac_rst_n, o_cam_rst_n, o_master_rst_n, o_enc_rst_n;
    logic o_scl_mdc_o, o_scl_mdc_oe, o_sda_mdio_o, o_sda_mdio_oe;
    logic o_cam_scl_i, o_sda_i;
    logic [`CB_LED_W-1:0] o_led;

    // reference model state
    cam_bridge_pkg::bringup_phase_t m_phase;
    logic       m_adv;
    logic [3:0] m_bar;
    // mem, mac, cam, master, enc from bit 0 up
    logic [4:0] m_rst;
    logic       m_vs_q, m_jd_q, m_ftog, m_jtog;
    logic [31:0] m_window = `CB_WIN_DEFAULT;
    logic [15:0] m_frate = '0;
    logic [15:0] m_jrate = '0;
    logic       m_fvalid = 1'b0;
    logic       m_jvalid = 1'b0;

    int cyc = 0;
    int errors = 0;
    int pin_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic [31:0] pin_seed = LCG_SEED;

    cam_bridge_top uut (.*);

    initial begin
        cam_port = 1'b0;
        forever #(CLK_PERIOD / 2) cam_port = ~cam_port;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one phase step by the bring-up rules
    function automatic cam_bridge_pkg::bringup_phase_t next_phase(
        input cam_bridge_pkg::bringup_phase_t ph);
        case (ph)
            cam_bridge_pkg::PH_IDLE: return cam_bridge_pkg::PH_MAC_INIT;
            cam_bridge_pkg::PH_MAC_INIT:
                return i_mac_init_done ? cam_bridge_pkg::PH_CAM_INIT : ph;
            cam_bridge_pkg::PH_CAM_INIT:
                return i_cam_init_done ? cam_bridge_pkg::PH_LINK_WAIT : ph;
            cam_bridge_pkg::PH_LINK_WAIT:
                return (i_mac_init_done && i_cam_init_done && i_mem_ready) ?
                       cam_bridge_pkg::PH_RUN : ph;
            default: return ph;
        endcase
    endfunction

    // expected read data of a mapped register
    function automatic logic [31:0] reg_value(input logic [3:0] addr);
        case (addr)
            cam_bridge_pkg::REG_STATUS:
                return {24'd0, m_jvalid, m_fvalid, i_mem_ready, i_cam_init_done,
                        i_mac_init_done, m_phase};
            cam_bridge_pkg::REG_WINDOW: return m_window;
            // live count stays 0 outside the pulse bursts
            cam_bridge_pkg::REG_FRAME_RATE: return {16'd0, m_frate};
            cam_bridge_pkg::REG_JPEG_RATE: return {16'd0, m_jrate};
            default: return 32'd0;
        endcase
    endfunction

    // scl out, scl oe, sda out, sda oe, returned scl, returned sda
    function automatic logic [5:0] routed_pins(input cam_bridge_pkg::bringup_phase_t ph);
        if (ph == cam_bridge_pkg::PH_IDLE || ph == cam_bridge_pkg::PH_MAC_INIT) begin
            return {i_mac_mdc, 1'b1, i_mac_mdio_o, i_mac_mdio_oe, i_scl_mdc, i_sda_mdio};
        end
        return {i_cam_scl_o, i_cam_scl_oe, i_cam_sda_o, i_cam_sda_oe, i_scl_mdc, i_sda_mdio};
    endfunction

    function automatic logic [5:0] led_pattern(input logic [3:0] bar, input logic ft,
                                               input logic jt);
        return {~ft, ~jt, bar};
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name, input int fails);
        tests_run++;
        if (fails == 0) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, fails);
        end
    endtask

    // setup then access with checks in the access cycle
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        logic [31:0] exp_data;
        @(posedge cam_port);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge cam_port);
        i_penable <= 1'b1;
        @(negedge cam_port);
        rdata = o_prdata;
        if (o_pslverr !== exp_err) begin
            log_mismatch($sformatf("o_pslverr[%h]", addr), exp_err, o_pslverr);
        end
        if (!wr && !exp_err) begin
            exp_data = reg_value(addr);
            if (o_prdata !== exp_data) begin
                log_mismatch($sformatf("o_prdata[%h]", addr), exp_data, o_prdata);
            end
        end
        @(posedge cam_port);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
        // new length is live from the end of the access cycle
        if (wr && !exp_err && addr == cam_bridge_pkg::REG_WINDOW) begin
            m_window = wdata;
        end
    endtask

    always @(posedge cam_port) begin
        cyc <= cyc + 1;
    end

    // cycle model of sequencer, led bar and event toggles
    always @(posedge cam_port or negedge rst_n) begin : model_step
        cam_bridge_pkg::bringup_phase_t nxt;
        if (!rst_n) begin
            m_phase <= cam_bridge_pkg::PH_IDLE;
            m_adv   <= 1'b0;
            m_bar   <= 4'hf;
            m_rst   <= 5'b0;
            m_vs_q  <= 1'b0;
            m_jd_q  <= 1'b0;
            m_ftog  <= 1'b0;
            m_jtog  <= 1'b0;
        end else begin
            nxt = next_phase(m_phase);
            m_phase <= nxt;
            m_adv   <= (nxt != m_phase);
            if (m_adv) m_bar <= {m_bar[2:0], 1'b0};
            // memory on entering mac_init and mac one cycle into it
            if (m_phase == cam_bridge_pkg::PH_IDLE) m_rst[0] <= 1'b1;
            if (m_phase == cam_bridge_pkg::PH_MAC_INIT) m_rst[1] <= 1'b1;
            if (nxt == cam_bridge_pkg::PH_CAM_INIT) m_rst[2] <= 1'b1;
            if (nxt == cam_bridge_pkg::PH_RUN) m_rst[3] <= 1'b1;
            // encoder one cycle behind the master
            if (m_phase == cam_bridge_pkg::PH_RUN) m_rst[4] <= 1'b1;
            m_vs_q <= i_vsync;
            m_jd_q <= i_jpeg_done;
            if (i_vsync && !m_vs_q) m_ftog <= ~m_ftog;
            if (i_jpeg_done && !m_jd_q) m_jtog <= ~m_jtog;
        end
    end

    // random management traffic on both masters and the pins
    always @(posedge cam_port) begin
        pin_seed = lcg_step(pin_seed);
        {i_mac_mdc, i_mac_mdio_o, i_mac_mdio_oe} <= pin_seed[26:24];
        {i_cam_scl_o, i_cam_scl_oe, i_cam_sda_o, i_cam_sda_oe} <= pin_seed[23:20];
        {i_scl_mdc, i_sda_mdio} <= pin_seed[19:18];
    end

    // checked every cycle mid period where outputs are settled
    always @(negedge cam_port) begin : compare_outputs
        logic [4:0] got_rst;
        logic [5:0] got_pins;
        logic [5:0] exp_pins;
        int n;
        got_rst = {o_enc_rst_n, o_master_rst_n, o_cam_rst_n, o_mac_rst_n, o_mem_rst_n};
        if (got_rst !== m_rst) log_mismatch("block resets", m_rst, got_rst);
        for (n = 1; n < 5; n++) begin
            if (got_rst[n] === 1'b1 && got_rst[n-1] !== 1'b1) begin
                report_failure($sformatf("reset %0d released before reset %0d", n, n - 1));
            end
        end
        got_pins = {o_scl_mdc_o, o_scl_mdc_oe, o_sda_mdio_o, o_sda_mdio_oe,
                    o_cam_scl_i, o_sda_i};
        exp_pins = routed_pins(m_phase);
        if (got_pins !== exp_pins) begin
            log_mismatch("shared pins", exp_pins, got_pins);
            pin_errs++;
        end
        if (o_led !== led_pattern(m_bar, m_ftog, m_jtog)) begin
            log_mismatch("o_led", led_pattern(m_bar, m_ftog, m_jtog), o_led);
        end
        if (o_pready !== 1'b1) log_mismatch("o_pready", 1'b1, o_pready);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] seed;
        logic [31:0] rd;
        logic [31:0] big;
        logic [3:0] bad_addr [4];
        int ord [3];
        int err0, tmp, j, k, delay, nf, nj, i, polls, t0;
        logic [2:0] last_phase;
        seed = LCG_SEED;
        bad_addr = '{4'h1, 4'h6, 4'hA, 4'hF};
        rst_n = 1'b0;
        {i_mac_init_done, i_cam_init_done, i_mem_ready} = 3'b000;
        {i_mac_mdc, i_mac_mdio_o, i_mac_mdio_oe} = 3'b000;
        {i_cam_scl_o, i_cam_scl_oe, i_cam_sda_o, i_cam_sda_oe} = 4'b0000;
        {i_scl_mdc, i_sda_mdio} = 2'b00;
        {i_vsync, i_jpeg_done} = 2'b00;
        {i_psel, i_penable, i_pwrite} = 3'b000;
        i_paddr = '0;
        i_pwdata = '0;

        // test 1 reads status while still in reset
        err0 = errors;
        apb_xfer(1'b0, cam_bridge_pkg::REG_STATUS, 32'd0, 1'b0, rd);
        @(negedge cam_port);
        if ({o_enc_rst_n, o_master_rst_n, o_cam_rst_n, o_mac_rst_n, o_mem_rst_n} !== 5'b0) begin
            report_failure("a block reset was released during reset");
        end
        if (o_led !== 6'h3f) log_mismatch("o_led", 32'h3f, o_led);
        repeat (2) @(posedge cam_port);
        rst_n <= 1'b1;
        apb_xfer(1'b0, cam_bridge_pkg::REG_WINDOW, 32'd0, 1'b0, rd);
        apb_xfer(1'b0, cam_bridge_pkg::REG_FRAME_RATE, 32'd0, 1'b0, rd);
        apb_xfer(1'b0, cam_bridge_pkg::REG_JPEG_RATE, 32'd0, 1'b0, rd);
        end_test("reset state", errors - err0);

        // test 2 raises the done flags in shuffled order
        err0 = errors;
        ord = '{0, 1, 2};
        for (k = 2; k > 0; k--) begin
            seed = lcg_step(seed);
            j = (seed >> 16) % (k + 1);
            tmp = ord[k];
            ord[k] = ord[j];
            ord[j] = tmp;
        end
        last_phase = 3'd0;
        for (k = 0; k < 3; k++) begin
            seed = lcg_step(seed);
            delay = 1 + (seed >> 16) % 40;
            repeat (delay) @(posedge cam_port);
            case (ord[k])
                0: i_mac_init_done <= 1'b1;
                1: i_cam_init_done <= 1'b1;
                default: i_mem_ready <= 1'b1;
            endcase
            apb_xfer(1'b0, cam_bridge_pkg::REG_STATUS, 32'd0, 1'b0, rd);
            if (rd[2:0] < last_phase) report_failure("phase moved backwards");
            last_phase = rd[2:0];
        end
        polls = 0;
        while (rd[2:0] != cam_bridge_pkg::PH_RUN && polls < 20) begin
            apb_xfer(1'b0, cam_bridge_pkg::REG_STATUS, 32'd0, 1'b0, rd);
            polls++;
        end
        if (rd[2:0] != cam_bridge_pkg::PH_RUN) report_failure("sequencer never reached run");
        repeat (3) @(posedge cam_port);
        @(negedge cam_port);
        if ({o_enc_rst_n, o_master_rst_n, o_cam_rst_n, o_mac_rst_n, o_mem_rst_n} !== 5'h1f) begin
            report_failure("not every block reset was released in run");
        end
        if (o_led[3:0] !== 4'b0000) log_mismatch("o_led[3:0]", 32'h0, o_led[3:0]);
        end_test("bring-up order", errors - err0);

        // test 3 relies on the routing compare made on every cycle so far
        repeat (40) @(posedge cam_port);
        end_test("pin routing", pin_errs);

        // test 4 drives bursts inside one short window
        err0 = errors;
        apb_xfer(1'b1, cam_bridge_pkg::REG_WINDOW, RATE_WINDOW, 1'b0, rd);
        t0 = cyc;
        seed = lcg_step(seed);
        nf = 1 + (seed >> 16) % 15;
        seed = lcg_step(seed);
        nj = 1 + (seed >> 16) % 15;
        for (i = 0; i < 15; i++) begin
            @(posedge cam_port);
            i_vsync     <= (i < nf);
            i_jpeg_done <= (i < nj);
            @(posedge cam_port);
            @(posedge cam_port);
            i_vsync     <= 1'b0;
            i_jpeg_done <= 1'b0;
            @(posedge cam_port);
        end
        // first window end lands exactly one length after the write
        while ((cyc - t0) < RATE_WINDOW + 10) @(posedge cam_port);
        m_frate  = nf;
        m_jrate  = nj;
        m_fvalid = 1'b1;
        m_jvalid = 1'b1;
        apb_xfer(1'b0, cam_bridge_pkg::REG_FRAME_RATE, 32'd0, 1'b0, rd);
        apb_xfer(1'b0, cam_bridge_pkg::REG_JPEG_RATE, 32'd0, 1'b0, rd);
        apb_xfer(1'b0, cam_bridge_pkg::REG_STATUS, 32'd0, 1'b0, rd);
        @(negedge cam_port);
        if (o_led[5] !== ~nf[0]) log_mismatch("o_led[5]", {31'd0, ~nf[0]}, o_led[5]);
        if (o_led[4] !== ~nj[0]) log_mismatch("o_led[4]", {31'd0, ~nj[0]}, o_led[4]);
        end_test("rate measurement", errors - err0);

        // test 5 sets a long window first so the rates hold still
        err0 = errors;
        seed = lcg_step(seed);
        big = seed | 32'h0100_0000;
        apb_xfer(1'b1, cam_bridge_pkg::REG_WINDOW, big, 1'b0, rd);
        for (k = 0; k < 4; k++) begin
            seed = lcg_step(seed);
            apb_xfer(1'b0, bad_addr[k], 32'd0, 1'b1, rd);
            apb_xfer(1'b1, bad_addr[k], seed, 1'b1, rd);
        end
        seed = lcg_step(seed);
        apb_xfer(1'b1, cam_bridge_pkg::REG_STATUS, seed, 1'b1, rd);
        apb_xfer(1'b1, cam_bridge_pkg::REG_FRAME_RATE, seed, 1'b1, rd);
        apb_xfer(1'b1, cam_bridge_pkg::REG_JPEG_RATE, seed, 1'b1, rd);
        apb_xfer(1'b0, cam_bridge_pkg::REG_STATUS, 32'd0, 1'b0, rd);
        apb_xfer(1'b0, cam_bridge_pkg::REG_FRAME_RATE, 32'd0, 1'b0, rd);
        apb_xfer(1'b0, cam_bridge_pkg::REG_JPEG_RATE, 32'd0, 1'b0, rd);
        apb_xfer(1'b0, cam_bridge_pkg::REG_WINDOW, 32'd0, 1'b0, rd);
        if (rd !== big) log_mismatch("window readback", big, rd);
        end_test("apb errors", errors - err0);

        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src/cam_bridge_top.sv
`include "cam_bridge_config.svh"

module cam_bridge_top (
    input  logic                  cam_port,
    input  logic                  rst_n,

    // done flags
    input  logic                  i_mac_init_done,
    input  logic                  i_cam_init_done,
    input  logic                  i_mem_ready,

    // mac mdio master
    input  logic                  i_mac_mdc,
    input  logic                  i_mac_mdio_o,
    input  logic                  i_mac_mdio_oe,

    // camera sccb master
    input  logic                  i_cam_scl_o,
    input  logic                  i_cam_scl_oe,
    input  logic                  i_cam_sda_o,
    input  logic                  i_cam_sda_oe,

    // shared pin inputs from the board wrapper
    input  logic                  i_scl_mdc,
    input  logic                  i_sda_mdio,

    // events to measure
    input  logic                  i_vsync,
    input  logic                  i_jpeg_done,

    // apb slave
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [`CB_ADDR_W-1:0] i_paddr,
    input  logic [`CB_WIN_W-1:0]  i_pwdata,
    output logic [`CB_WIN_W-1:0]  o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,

    // block resets
    output logic                  o_mem_rst_n,
    output logic                  o_mac_rst_n,
    output logic                  o_cam_rst_n,
    output logic                  o_master_rst_n,
    output logic                  o_enc_rst_n,

    // shared pin outputs to the board wrapper
    output logic                  o_scl_mdc_o,
    output logic                  o_scl_mdc_oe,
    output logic                  o_sda_mdio_o,
    output logic                  o_sda_mdio_oe,

    // pin values back to the masters
    output logic                  o_cam_scl_i,
    output logic                  o_sda_i,

    output logic [`CB_LED_W-1:0]  o_led
);

    logic window_end;

    seq_status_if seq_st ();
    rate_if       frame_rt ();
    rate_if       jpeg_rt ();

    bringup_sequencer u_seq (
        .cam_port        (cam_port),
        .rst_n           (rst_n),
        .i_mac_init_done (i_mac_init_done),
        .i_cam_init_done (i_cam_init_done),
        .i_mem_ready     (i_mem_ready),
        .i_mac_mdc       (i_mac_mdc),
        .i_mac_mdio_o    (i_mac_mdio_o),
        .i_mac_mdio_oe   (i_mac_mdio_oe),
        .i_cam_scl_o     (i_cam_scl_o),
        .i_cam_scl_oe    (i_cam_scl_oe),
        .i_cam_sda_o     (i_cam_sda_o),
        .i_cam_sda_oe    (i_cam_sda_oe),
        .i_scl_mdc       (i_scl_mdc),
        .i_sda_mdio      (i_sda_mdio),
        .o_mem_rst_n     (o_mem_rst_n),
        .o_mac_rst_n     (o_mac_rst_n),
        .o_cam_rst_n     (o_cam_rst_n),
        .o_master_rst_n  (o_master_rst_n),
        .o_enc_rst_n     (o_enc_rst_n),
        .o_scl_mdc_o     (o_scl_mdc_o),
        .o_scl_mdc_oe    (o_scl_mdc_oe),
        .o_sda_mdio_o    (o_sda_mdio_o),
        .o_sda_mdio_oe   (o_sda_mdio_oe),
        .o_cam_scl_i     (o_cam_scl_i),
        .o_sda_i         (o_sda_i),
        .o_seq           (seq_st.source)
    );

    // frame starts on vsync rising edges
    rate_meter frame_meter (
        .cam_port     (cam_port),
        .rst_n        (rst_n),
        .i_event      (i_vsync),
        .i_window_end (window_end),
        .o_rate       (frame_rt.source)
    );

    // encoder completions
    rate_meter jpeg_meter (
        .cam_port     (cam_port),
        .rst_n        (rst_n),
        .i_event      (i_jpeg_done),
        .i_window_end (window_end),
        .o_rate       (jpeg_rt.source)
    );

    status_apb_regs u_regs (
        .cam_port     (cam_port),
        .rst_n        (rst_n),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_window_end (window_end),
        .o_led        (o_led),
        .i_seq        (seq_st.sink),
        .i_frame      (frame_rt.sink),
        .i_jpeg       (jpeg_rt.sink)
    );

endmodule

//--- src/status_apb_regs.sv
`include "cam_bridge_config.svh"

module status_apb_regs (
    input  logic                  cam_port,
    input  logic                  rst_n,

    // apb slave
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [`CB_ADDR_W-1:0] i_paddr,
    input  logic [`CB_WIN_W-1:0]  i_pwdata,
    output logic [`CB_WIN_W-1:0]  o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,

    // shared measurement window to both meters
    output logic                  o_window_end,
    // active low
    output logic [`CB_LED_W-1:0]  o_led,

    seq_status_if.sink            i_seq,
    rate_if.sink                  i_frame,
    rate_if.sink                  i_jpeg
);

    localparam cam_bridge_pkg::win_t WIN_ONE = 1;

    cam_bridge_pkg::win_t  window_q;
    cam_bridge_pkg::win_t  timer_q;
    logic [`CB_BAR_W-1:0]  bar_q;
    logic [`CB_WIN_W-1:0]  rd_data;
    logic                  access;
    logic                  addr_hit;
    logic                  read_only;
    logic                  win_wr;
    logic                  timer_hit;

    // second cycle of a transfer
    assign access = i_psel & i_penable;

    // address decode and read mux
    always_comb begin
        rd_data   = '0;
        addr_hit  = 1'b1;
        read_only = 1'b1;
        case (i_paddr)
            cam_bridge_pkg::REG_STATUS: begin
                rd_data[2:0] = i_seq.phase;
                rd_data[3]   = i_seq.mac_done;
                rd_data[4]   = i_seq.cam_done;
                rd_data[5]   = i_seq.mem_ready;
                // first window closed on each meter
                rd_data[6]   = i_frame.valid;
                rd_data[7]   = i_jpeg.valid;
            end
            cam_bridge_pkg::REG_WINDOW: begin
                rd_data   = window_q;
                read_only = 1'b0;
            end
            // latched rate low, running count high
            cam_bridge_pkg::REG_FRAME_RATE: begin
                rd_data[`CB_RATE_W-1:0]            = i_frame.rate;
                rd_data[2*`CB_RATE_W-1:`CB_RATE_W] = i_frame.count;
            end
            cam_bridge_pkg::REG_JPEG_RATE: begin
                rd_data[`CB_RATE_W-1:0]            = i_jpeg.rate;
                rd_data[2*`CB_RATE_W-1:`CB_RATE_W] = i_jpeg.count;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // only the window register takes writes
    assign win_wr    = access & i_pwrite & addr_hit & ~read_only;
    assign o_prdata  = rd_data;
    assign o_pready  = 1'b1;
    assign o_pslverr = access & (~addr_hit | (i_pwrite & read_only));

    // window closes on its last cycle
    assign timer_hit    = (timer_q == (window_q - WIN_ONE));
    // a new length restarts the count, no stale pulse
    assign o_window_end = timer_hit & ~win_wr;

    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            window_q <= `CB_WIN_DEFAULT;
            timer_q  <= '0;
            bar_q    <= '1;
        end else begin
            if (win_wr) begin
                window_q <= i_pwdata;
                timer_q  <= '0;
            end else if (timer_hit) begin
                timer_q <= '0;
            end else begin
                timer_q <= timer_q + WIN_ONE;
            end
            // one more led lit per phase
            if (i_seq.advance) begin
                bar_q <= bar_q << 1;
            end
        end
    end

    // activity leds blink with the event toggles
    assign o_led = {~i_frame.toggle, ~i_jpeg.toggle, bar_q};

endmodule

//--- src/rate_meter.sv
`include "cam_bridge_config.svh"

module rate_meter (
    input  logic     cam_port,
    input  logic     rst_n,
    // level, already synchronous to cam_port
    input  logic     i_event,
    // one cycle pulse from the window timer
    input  logic     i_window_end,
    rate_if.source   o_rate
);

    logic                  event_q;
    logic                  rise;
    logic                  toggle_q;
    logic                  valid_q;
    cam_bridge_pkg::rate_t count_q;
    cam_bridge_pkg::rate_t rate_q;

    // rising edge against last cycle's level
    assign rise = i_event & ~event_q;

    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            event_q  <= 1'b0;
            toggle_q <= 1'b0;
            valid_q  <= 1'b0;
            count_q  <= '0;
            rate_q   <= '0;
        end else begin
            event_q <= i_event;
            if (rise) begin
                toggle_q <= ~toggle_q;
            end
            if (i_window_end) begin
                rate_q  <= count_q;
                valid_q <= 1'b1;
                // edge on the boundary opens the next window
                count_q <= rise ? cam_bridge_pkg::rate_t'(1) : '0;
            end else if (rise && (count_q != '1)) begin
                // sticks at full scale
                count_q <= count_q + cam_bridge_pkg::rate_t'(1);
            end
        end
    end

    assign o_rate.rate   = rate_q;
    assign o_rate.valid  = valid_q;
    assign o_rate.count  = count_q;
    assign o_rate.toggle = toggle_q;

endmodule

//--- src/bringup_sequencer.sv
`include "cam_bridge_config.svh"

module bringup_sequencer (
    input  logic cam_port,
    input  logic rst_n,

    // done flags from the blocks
    input  logic i_mac_init_done,
    input  logic i_cam_init_done,
    input  logic i_mem_ready,

    // mac mdio master
    input  logic i_mac_mdc,
    input  logic i_mac_mdio_o,
    input  logic i_mac_mdio_oe,

    // camera sccb master
    input  logic i_cam_scl_o,
    input  logic i_cam_scl_oe,
    input  logic i_cam_sda_o,
    input  logic i_cam_sda_oe,

    // shared pins, input side
    input  logic i_scl_mdc,
    input  logic i_sda_mdio,

    // block resets, active low, held until released
    output logic o_mem_rst_n,
    output logic o_mac_rst_n,
    output logic o_cam_rst_n,
    output logic o_master_rst_n,
    output logic o_enc_rst_n,

    // shared pins, output side
    output logic o_scl_mdc_o,
    output logic o_scl_mdc_oe,
    output logic o_sda_mdio_o,
    output logic o_sda_mdio_oe,

    // pin values back to the masters
    output logic o_cam_scl_i,
    output logic o_sda_i,

    seq_status_if.source o_seq
);

    cam_bridge_pkg::bringup_phase_t phase_q;
    cam_bridge_pkg::bringup_phase_t phase_d;
    logic advance_q;
    logic mac_owns;
    logic all_ready;

    // link wait needs every block up at once
    assign all_ready = i_mac_init_done & i_cam_init_done & i_mem_ready;

    // next phase, no skipping, unbounded wait
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            cam_bridge_pkg::PH_IDLE:
                phase_d = cam_bridge_pkg::PH_MAC_INIT;
            cam_bridge_pkg::PH_MAC_INIT:
                if (i_mac_init_done) phase_d = cam_bridge_pkg::PH_CAM_INIT;
            cam_bridge_pkg::PH_CAM_INIT:
                if (i_cam_init_done) phase_d = cam_bridge_pkg::PH_LINK_WAIT;
            cam_bridge_pkg::PH_LINK_WAIT:
                if (all_ready) phase_d = cam_bridge_pkg::PH_RUN;
            default:
                phase_d = phase_q;
        endcase
    end

    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            phase_q        <= cam_bridge_pkg::PH_IDLE;
            advance_q      <= 1'b0;
            o_mem_rst_n    <= 1'b0;
            o_mac_rst_n    <= 1'b0;
            o_cam_rst_n    <= 1'b0;
            o_master_rst_n <= 1'b0;
            o_enc_rst_n    <= 1'b0;
        end else begin
            phase_q   <= phase_d;
            advance_q <= (phase_d != phase_q);
            // releases are sticky, nothing clears them short of rst_n
            if (phase_q == cam_bridge_pkg::PH_IDLE) begin
                o_mem_rst_n <= 1'b1;
            end
            if (phase_q == cam_bridge_pkg::PH_MAC_INIT) begin
                o_mac_rst_n <= 1'b1;
            end
            // camera comes out together with the move to cam_init
            if (phase_d == cam_bridge_pkg::PH_CAM_INIT) begin
                o_cam_rst_n <= 1'b1;
            end
            if (phase_d == cam_bridge_pkg::PH_RUN) begin
                o_master_rst_n <= 1'b1;
            end
            // encoder trails the streaming master by one cycle
            if (phase_q == cam_bridge_pkg::PH_RUN) begin
                o_enc_rst_n <= 1'b1;
            end
        end
    end

    // mac drives the pins until the camera phase
    assign mac_owns = (phase_q == cam_bridge_pkg::PH_IDLE) ||
                      (phase_q == cam_bridge_pkg::PH_MAC_INIT);

    // mdc is a push-pull clock, always driven for the mac
    assign o_scl_mdc_o   = mac_owns ? i_mac_mdc     : i_cam_scl_o;
    assign o_scl_mdc_oe  = mac_owns ? 1'b1          : i_cam_scl_oe;
    assign o_sda_mdio_o  = mac_owns ? i_mac_mdio_o  : i_cam_sda_o;
    assign o_sda_mdio_oe = mac_owns ? i_mac_mdio_oe : i_cam_sda_oe;

    // data pin goes back to both, clock pin only matters to sccb
    assign o_cam_scl_i = i_scl_mdc;
    assign o_sda_i     = i_sda_mdio;

    // status towards the register block
    assign o_seq.phase     = phase_q;
    assign o_seq.mac_done  = i_mac_init_done;
    assign o_seq.cam_done  = i_cam_init_done;
    assign o_seq.mem_ready = i_mem_ready;
    assign o_seq.advance   = advance_q;

endmodule

//--- src/cam_bridge_ifs.sv
`include "cam_bridge_config.svh"

// sequencer progress towards the register block
interface seq_status_if;
    cam_bridge_pkg::bringup_phase_t phase;
    logic mac_done;
    logic cam_done;
    logic mem_ready;
    // one cycle, first cycle of each new phase
    logic advance;

    modport source (
        output phase, mac_done, cam_done, mem_ready, advance
    );

    modport sink (
        input phase, mac_done, cam_done, mem_ready, advance
    );
endinterface

// one rate meter towards the register block
interface rate_if;
    // count of the last complete window
    cam_bridge_pkg::rate_t rate;
    // set once the first window has closed
    logic valid;
    // running count of the current window
    cam_bridge_pkg::rate_t count;
    // flips on every counted edge
    logic toggle;

    modport source (
        output rate, valid, count, toggle
    );

    modport sink (
        input rate, valid, count, toggle
    );
endinterface

//--- src/cam_bridge_pkg.sv
`include "cam_bridge_config.svh"

package cam_bridge_pkg;

    // bring-up phases, in the order they are stepped
    typedef enum logic [2:0] {
        PH_IDLE      = 3'd0,
        // memory out of reset, mac being configured
        PH_MAC_INIT  = 3'd1,
        // camera owns the shared management pins from here on
        PH_CAM_INIT  = 3'd2,
        // wait for mac, camera and memory together
        PH_LINK_WAIT = 3'd3,
        PH_RUN       = 3'd4
    } bringup_phase_t;

    // apb register map
    typedef enum logic [`CB_ADDR_W-1:0] {
        REG_STATUS     = `CB_OFS_STATUS,
        REG_WINDOW     = `CB_OFS_WINDOW,
        REG_FRAME_RATE = `CB_OFS_FRAME_RATE,
        REG_JPEG_RATE  = `CB_OFS_JPEG_RATE
    } reg_addr_t;

    // event count per window
    typedef logic [`CB_RATE_W-1:0] rate_t;

    // window length in cam_port cycles
    typedef logic [`CB_WIN_W-1:0] win_t;

endpackage

//--- src/cam_bridge_config.svh
`ifndef CAM_BRIDGE_CONFIG_SVH
`define CAM_BRIDGE_CONFIG_SVH

// width of one rate count and of the live event count
`define CB_RATE_W 16

// window length register, also the apb data width
`define CB_WIN_W 32

// about one second of cam_port at 84 MHz
`define CB_WIN_DEFAULT 32'd84000000

// apb byte offset width
`define CB_ADDR_W 4

// progress bar plus two activity leds
`define CB_LED_W 6

// register offsets
// status is read-only
`define CB_OFS_STATUS 4'h0
// window length is read/write
`define CB_OFS_WINDOW 4'h4
// latched frame rate is read-only
`define CB_OFS_FRAME_RATE 4'h8
// latched jpeg rate is read-only
`define CB_OFS_JPEG_RATE 4'hC

// progress leds that shift on each phase advance
`define CB_BAR_W 4

`endif
